// ==== verilog/tmu_tag_pkg.sv ====
/*
 * Shared sizes and types for the texel cache tag stage.
 * Sizes assume a 26-bit memory space, an 8 KB cache and 32-byte lines.
 * A tag entry is carried as {valid, tag}, TAG_W+1 bits wide.
 */
package tmu_tag_pkg;

	localparam int FML_DEPTH = 26;
	localparam int CACHE_DEPTH = 13;
	localparam int LINE_DEPTH = 5;
	localparam int IDX_W = CACHE_DEPTH - LINE_DEPTH;
	localparam int TAG_W = FML_DEPTH - CACHE_DEPTH;
	localparam int N_LINES = 1 << IDX_W;

	typedef logic [FML_DEPTH-1:0] texel_adr_t;
	// Destination addresses count 16-bit pixels, so one bit less.
	typedef logic [FML_DEPTH-2:0] dst_adr_t;
	typedef logic [5:0] frac_t;
	typedef logic [IDX_W-1:0] line_idx_t;
	typedef logic [TAG_W-1:0] tag_t;

	// One bit per channel, a in bit 0 up to d in bit 3.
	typedef logic [3:0] chan_vec_t;

	typedef struct packed {
		dst_adr_t dadr;
		texel_adr_t tadra;
		texel_adr_t tadrb;
		texel_adr_t tadrc;
		texel_adr_t tadrd;
		frac_t x_frac;
		frac_t y_frac;
	} tex_req_t;

	typedef enum logic [2:0] {
		chan_a,
		chan_b,
		chan_c,
		chan_d,
		flush_line
	} tag_sel_t;

	typedef enum logic [1:0] {RUNNING, RESOLVE_MISS, FLUSH} tag_state_t;

endpackage

// ==== verilog/tmu_tag_ram.sv ====
/*
 * Tag RAM with one read and one write port and a registered read.
 * Read data only changes while re_i is high. A write to the line being
 * read is forwarded, so the new entry is seen at once.
 */
`timescale 1ns/100ps

module tmu_tag_ram
	import tmu_tag_pkg::*;
(
	input  logic             sys_clk,
	input  line_idx_t        ra_i,
	input  logic             re_i,
	output logic [TAG_W:0]   rd_o,
	input  line_idx_t        wa_i,
	input  logic             we_i,
	input  logic [TAG_W:0]   wd_i
);

	logic [TAG_W:0] mem [N_LINES];

	always_ff @(posedge sys_clk) begin
		if (we_i)
			mem[wa_i] <= wd_i;
		if (re_i) begin
			if (we_i && (wa_i == ra_i))
				rd_o <= wd_i;
			else
				rd_o <= mem[ra_i];
		end
	end

endmodule

// ==== verilog/tmu_tag_leader.sv ====
/*
 * Channel validity and leader election for one bilinear request.
 * Purely combinational; works on the live request.
 */
`timescale 1ns/100ps

module tmu_tag_leader
	import tmu_tag_pkg::*;
(
	input  tex_req_t  req_i,
	output line_idx_t idx_a_o,
	output line_idx_t idx_b_o,
	output line_idx_t idx_c_o,
	output line_idx_t idx_d_o,
	output chan_vec_t lead_o
);

	logic valid_b;
	logic valid_c;
	logic valid_d;

	assign idx_a_o = req_i.tadra[CACHE_DEPTH-1:LINE_DEPTH];
	assign idx_b_o = req_i.tadrb[CACHE_DEPTH-1:LINE_DEPTH];
	assign idx_c_o = req_i.tadrc[CACHE_DEPTH-1:LINE_DEPTH];
	assign idx_d_o = req_i.tadrd[CACHE_DEPTH-1:LINE_DEPTH];

	// Channel a always contributes to the filtered pixel.
	assign valid_b = req_i.x_frac != '0;
	assign valid_c = req_i.y_frac != '0;
	assign valid_d = valid_b & valid_c;

	/*
	 * A channel leads when no later valid channel sits on the same line.
	 * Every line touched by the request then has exactly one leader.
	 */
	assign lead_o[0] = ~(valid_b & (idx_a_o == idx_b_o))
		& ~(valid_c & (idx_a_o == idx_c_o))
		& ~(valid_d & (idx_a_o == idx_d_o));
	assign lead_o[1] = valid_b
		& ~(valid_c & (idx_b_o == idx_c_o))
		& ~(valid_d & (idx_b_o == idx_d_o));
	assign lead_o[2] = valid_c & ~(valid_d & (idx_c_o == idx_d_o));
	assign lead_o[3] = valid_d;

endmodule

// ==== verilog/tmu_tag_lookup.sv ====
/*
 * Stage register, four tag RAMs and the per-channel miss compare.
 * Tags, indices and leaders are captured when tag_re_i is high.
 */
`timescale 1ns/100ps

module tmu_tag_lookup
	import tmu_tag_pkg::*;
(
	input  logic           sys_clk,
	input  logic           sys_rst,
	input  tex_req_t       req_i,
	input  line_idx_t      idx_a_i,
	input  line_idx_t      idx_b_i,
	input  line_idx_t      idx_c_i,
	input  line_idx_t      idx_d_i,
	input  chan_vec_t      lead_i,
	input  logic           stb_i,
	input  logic           tag_re_i,
	input  logic           tag_we_i,
	input  line_idx_t      wa_i,
	input  logic [TAG_W:0] wd_i,
	output logic           req_valid_o,
	output chan_vec_t      miss_o,
	output tag_t           tag_a_o,
	output tag_t           tag_b_o,
	output tag_t           tag_c_o,
	output tag_t           tag_d_o,
	output line_idx_t      idx_ra_o,
	output line_idx_t      idx_rb_o,
	output line_idx_t      idx_rc_o,
	output line_idx_t      idx_rd_o
);

	line_idx_t      idx_live [4];
	tag_t           tag_live [4];
	line_idx_t      idx_r [4];
	tag_t           tag_r [4];
	chan_vec_t      lead_r;
	logic [TAG_W:0] rd [4];

	assign idx_live[0] = idx_a_i;
	assign idx_live[1] = idx_b_i;
	assign idx_live[2] = idx_c_i;
	assign idx_live[3] = idx_d_i;

	assign tag_live[0] = req_i.tadra[FML_DEPTH-1:CACHE_DEPTH];
	assign tag_live[1] = req_i.tadrb[FML_DEPTH-1:CACHE_DEPTH];
	assign tag_live[2] = req_i.tadrc[FML_DEPTH-1:CACHE_DEPTH];
	assign tag_live[3] = req_i.tadrd[FML_DEPTH-1:CACHE_DEPTH];

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			req_valid_o <= 1'b0;
		else if (tag_re_i)
			req_valid_o <= stb_i;
	end

	always_ff @(posedge sys_clk) begin
		if (tag_re_i) begin
			tag_r <= tag_live;
			idx_r <= idx_live;
			lead_r <= lead_i;
		end
	end

	for (genvar i = 0; i < 4; i++) begin : g_chan
		// All four RAMs get the same writes, so they hold identical copies.
		tmu_tag_ram i_ram (
			.sys_clk(sys_clk),
			.ra_i(idx_live[i]),
			.re_i(tag_re_i),
			.rd_o(rd[i]),
			.wa_i(wa_i),
			.we_i(tag_we_i),
			.wd_i(wd_i)
		);

		assign miss_o[i] = lead_r[i] & (~rd[i][TAG_W] | (rd[i][TAG_W-1:0] != tag_r[i]));
	end

	assign tag_a_o = tag_r[0];
	assign tag_b_o = tag_r[1];
	assign tag_c_o = tag_r[2];
	assign tag_d_o = tag_r[3];

	assign idx_ra_o = idx_r[0];
	assign idx_rb_o = idx_r[1];
	assign idx_rc_o = idx_r[2];
	assign idx_rd_o = idx_r[3];

endmodule

// ==== verilog/tmu_tag_write.sv ====
/*
 * Tag write source selection and the flush line counter.
 * The counter clears whenever flush_run_i is low.
 */
`timescale 1ns/100ps

module tmu_tag_write
	import tmu_tag_pkg::*;
(
	input  logic           sys_clk,
	input  tag_sel_t       sel_i,
	input  logic           flush_run_i,
	input  tag_t           tag_a_i,
	input  tag_t           tag_b_i,
	input  tag_t           tag_c_i,
	input  tag_t           tag_d_i,
	input  line_idx_t      idx_a_i,
	input  line_idx_t      idx_b_i,
	input  line_idx_t      idx_c_i,
	input  line_idx_t      idx_d_i,
	output line_idx_t      wa_o,
	output logic [TAG_W:0] wd_o,
	output logic           flush_done_o
);

	line_idx_t flush_cnt;

	always_ff @(posedge sys_clk) begin
		if (flush_run_i)
			flush_cnt <= flush_cnt + 1'b1;
		else
			flush_cnt <= '0;
	end

	assign flush_done_o = &flush_cnt;

	always_comb begin
		case (sel_i)
			chan_a: begin
				wa_o = idx_a_i;
				wd_o = {1'b1, tag_a_i};
			end
			chan_b: begin
				wa_o = idx_b_i;
				wd_o = {1'b1, tag_b_i};
			end
			chan_c: begin
				wa_o = idx_c_i;
				wd_o = {1'b1, tag_c_i};
			end
			chan_d: begin
				wa_o = idx_d_i;
				wd_o = {1'b1, tag_d_i};
			end
			default: begin
				// Flush clears the valid bit of one line per cycle.
				wa_o = flush_cnt;
				wd_o = '0;
			end
		endcase
	end

endmodule

// ==== verilog/tmu_tag_ctrl.sv ====
/*
 * Control FSM of the tag stage: normal flow, multi-miss resolution and flush.
 * Misses are served lowest channel first, one tag write per cycle.
 * Leaving RESOLVE_MISS or FLUSH empties the stage register.
 */
`timescale 1ns/100ps

module tmu_tag_ctrl
	import tmu_tag_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst,
	input  logic      flush_i,
	output logic      busy_o,
	input  logic      req_valid_i,
	input  chan_vec_t miss_i,
	input  logic      pipe_ack_i,
	input  logic      flush_done_i,
	output logic      pipe_ack_o,
	output logic      pipe_stb_o,
	output logic      tag_re_o,
	output logic      tag_we_o,
	output tag_sel_t  sel_o,
	output logic      flush_run_o
);

	tag_state_t state;
	tag_state_t next_state;
	chan_vec_t  miss_mask;
	chan_vec_t  pending;
	chan_vec_t  sel_bit;
	logic       mask_init;
	logic       mask_we;
	logic       multi_miss;

	function automatic tag_sel_t first_chan(chan_vec_t v);
		if (v[0])
			return chan_a;
		else if (v[1])
			return chan_b;
		else if (v[2])
			return chan_c;
		else
			return chan_d;
	endfunction

	// Two or more bits set when clearing the lowest one leaves something.
	assign multi_miss = (miss_i & (miss_i - 1'b1)) != '0;
	assign pending = miss_i & miss_mask;
	assign sel_bit = chan_vec_t'(4'b0001 << sel_o[1:0]);

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= RUNNING;
		else
			state <= next_state;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			miss_mask <= '0;
		else if (mask_init)
			miss_mask <= ~sel_bit;
		else if (mask_we)
			miss_mask <= miss_mask & ~sel_bit;
	end

	always_comb begin
		next_state = state;
		pipe_ack_o = 1'b0;
		pipe_stb_o = 1'b0;
		busy_o = 1'b0;
		tag_re_o = 1'b0;
		tag_we_o = 1'b0;
		sel_o = chan_a;
		mask_init = 1'b0;
		mask_we = 1'b0;
		flush_run_o = 1'b0;

		case (state)
			RUNNING: begin
				pipe_ack_o = 1'b1;
				tag_re_o = 1'b1;
				mask_init = 1'b1;
				if (req_valid_i) begin
					pipe_stb_o = 1'b1;
					busy_o = 1'b1;
					tag_we_o = |miss_i;
					sel_o = first_chan(miss_i);
					if (!pipe_ack_i) begin
						// Freeze everything until downstream takes the item.
						pipe_ack_o = 1'b0;
						tag_re_o = 1'b0;
						tag_we_o = 1'b0;
					end
					if (multi_miss) begin
						pipe_ack_o = 1'b0;
						tag_re_o = 1'b0;
						if (pipe_ack_i)
							next_state = RESOLVE_MISS;
					end
				end
				if (flush_i)
					next_state = FLUSH;
			end
			RESOLVE_MISS: begin
				busy_o = 1'b1;
				if (pending != '0) begin
					tag_we_o = 1'b1;
					mask_we = 1'b1;
					sel_o = first_chan(pending);
				end else begin
					tag_re_o = 1'b1;
					next_state = RUNNING;
				end
			end
			FLUSH: begin
				busy_o = 1'b1;
				sel_o = flush_line;
				tag_we_o = 1'b1;
				flush_run_o = 1'b1;
				if (flush_done_i) begin
					tag_re_o = 1'b1;
					next_state = RUNNING;
				end
			end
			default: next_state = RUNNING;
		endcase
	end

endmodule

// ==== verilog/tmu_tag_top.sv ====
/*
 * Tag stage of the texel cache, one cycle of latency.
 * Tag contents are undefined after reset, so flush before first use.
 */
`timescale 1ns/100ps

module tmu_tag_top
	import tmu_tag_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst,
	input  logic      flush_i,
	output logic      busy_o,
	input  logic      pipe_stb_i,
	output logic      pipe_ack_o,
	input  tex_req_t  req_i,
	output logic      pipe_stb_o,
	input  logic      pipe_ack_i,
	output tex_req_t  req_o,
	output chan_vec_t miss_o
);

	line_idx_t      idx_a, idx_b, idx_c, idx_d;
	line_idx_t      idx_ra, idx_rb, idx_rc, idx_rd;
	tag_t           tag_a, tag_b, tag_c, tag_d;
	chan_vec_t      lead;
	logic           tag_re;
	logic           tag_we;
	tag_sel_t       sel;
	logic           flush_run;
	logic           flush_done;
	logic           req_valid;
	line_idx_t      wa;
	logic [TAG_W:0] wd;

	tmu_tag_leader i_leader (
		.req_i(req_i),
		.idx_a_o(idx_a),
		.idx_b_o(idx_b),
		.idx_c_o(idx_c),
		.idx_d_o(idx_d),
		.lead_o(lead)
	);

	// Only a request actually acknowledged upstream enters the stage.
	tmu_tag_lookup i_lookup (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.req_i(req_i),
		.idx_a_i(idx_a),
		.idx_b_i(idx_b),
		.idx_c_i(idx_c),
		.idx_d_i(idx_d),
		.lead_i(lead),
		.stb_i(pipe_stb_i & pipe_ack_o),
		.tag_re_i(tag_re),
		.tag_we_i(tag_we),
		.wa_i(wa),
		.wd_i(wd),
		.req_valid_o(req_valid),
		.miss_o(miss_o),
		.tag_a_o(tag_a),
		.tag_b_o(tag_b),
		.tag_c_o(tag_c),
		.tag_d_o(tag_d),
		.idx_ra_o(idx_ra),
		.idx_rb_o(idx_rb),
		.idx_rc_o(idx_rc),
		.idx_rd_o(idx_rd)
	);

	tmu_tag_write i_write (
		.sys_clk(sys_clk),
		.sel_i(sel),
		.flush_run_i(flush_run),
		.tag_a_i(tag_a),
		.tag_b_i(tag_b),
		.tag_c_i(tag_c),
		.tag_d_i(tag_d),
		.idx_a_i(idx_ra),
		.idx_b_i(idx_rb),
		.idx_c_i(idx_rc),
		.idx_d_i(idx_rd),
		.wa_o(wa),
		.wd_o(wd),
		.flush_done_o(flush_done)
	);

	tmu_tag_ctrl i_ctrl (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush_i),
		.busy_o(busy_o),
		.req_valid_i(req_valid),
		.miss_i(miss_o),
		.pipe_ack_i(pipe_ack_i),
		.flush_done_i(flush_done),
		.pipe_ack_o(pipe_ack_o),
		.pipe_stb_o(pipe_stb_o),
		.tag_re_o(tag_re),
		.tag_we_o(tag_we),
		.sel_o(sel),
		.flush_run_o(flush_run)
	);

	// The request travels alongside the lookup and is loaded with it.
	always_ff @(posedge sys_clk) begin
		if (tag_re)
			req_o <= req_i;
	end

endmodule

// ==== bench/tb_tmu_tag.sv ====
/*
 * Table-driven testbench for the texel cache tag stage.
 * A software tag model predicts misses; downstream stalls come from the table.
 * Flushes are only issued while the stage is idle.
 */
`timescale 1ns/100ps

module tb_tmu_tag
	import tmu_tag_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int N_REQ = 16;
	localparam int unsigned SEED = 32'ha0dd_daae;
	// Each request needs far fewer than 20 cycles, and the test flushes twice.
	localparam int TIMEOUT_CYC = N_REQ * 20 + 2 * (N_LINES + 8) + 8;

	typedef struct packed {
		texel_adr_t a;
		texel_adr_t b;
		texel_adr_t c;
		texel_adr_t d;
		frac_t      xf;
		frac_t      yf;
		chan_vec_t  exp_miss;
		int         stall;
		logic       flush;
	} stim_t;

	logic      sys_clk;
	logic      sys_rst;
	logic      flush_i;
	logic      busy_o;
	logic      pipe_stb_i;
	logic      pipe_ack_o;
	tex_req_t  req_i;
	logic      pipe_stb_o;
	logic      pipe_ack_i;
	tex_req_t  req_o;
	chan_vec_t miss_o;

	stim_t     tab [N_REQ];
	tex_req_t  reqs [N_REQ];
	int        n_rows;
	logic      model_valid [N_LINES];
	tag_t      model_tag [N_LINES];
	tex_req_t  exp_req_q [$];
	chan_vec_t exp_miss_q [$];
	int        out_cnt;
	int        err_value;
	int        err_other;

	tmu_tag_top i_tmu_tag_top (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush_i),
		.busy_o(busy_o),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.req_i(req_i),
		.pipe_stb_o(pipe_stb_o),
		.pipe_ack_i(pipe_ack_i),
		.req_o(req_o),
		.miss_o(miss_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	initial begin
		#(TIMEOUT_CYC * CLK_PERIOD);
		$display("Timeout after %0d cycles, the stage stopped making progress", TIMEOUT_CYC);
		$display("Test FAILED");
		$finish;
	end

	function automatic texel_adr_t adr(input int tag, input int idx, input int off);
		return {tag_t'(tag), line_idx_t'(idx), LINE_DEPTH'(off)};
	endfunction

	task automatic add_row(input texel_adr_t a, input texel_adr_t b, input texel_adr_t c,
			input texel_adr_t d, input frac_t xf, input frac_t yf, input chan_vec_t miss,
			input int stall, input logic flush);
		tab[n_rows] = '{a, b, c, d, xf, yf, miss, stall, flush};
		reqs[n_rows] = '{dst_adr_t'($urandom()), a, b, c, d, xf, yf};
		n_rows++;
	endtask

	task automatic fill_table();
		n_rows = 0;
		// Four distinct lines miss after the flush, then hit on the repeat.
		add_row(adr(1, 10, 0), adr(1, 11, 4), adr(1, 12, 8), adr(1, 13, 12), 6'd8, 6'd8, 4'b1111, 0, 1);
		add_row(adr(1, 10, 0), adr(1, 11, 4), adr(1, 12, 8), adr(1, 13, 12), 6'd8, 6'd8, 4'b0000, 0, 0);
		// Shared lines and zero fractions leave only the elected leaders.
		add_row(adr(1, 20, 0), adr(1, 20, 8), adr(1, 21, 0), adr(1, 21, 8), 6'd4, 6'd9, 4'b1010, 2, 0);
		add_row(adr(1, 30, 0), adr(1, 31, 0), adr(1, 32, 0), adr(1, 33, 0), 6'd0, 6'd5, 4'b0101, 1, 0);
		add_row(adr(1, 31, 0), adr(1, 30, 4), adr(1, 32, 0), adr(1, 33, 0), 6'd3, 6'd0, 4'b0001, 0, 0);
		// Same index with another tag replaces the entry, the old tag misses again.
		add_row(adr(2, 10, 0), adr(7, 70, 0), adr(7, 71, 0), adr(7, 72, 0), 6'd0, 6'd0, 4'b0001, 0, 0);
		add_row(adr(1, 10, 0), adr(7, 70, 0), adr(7, 71, 0), adr(7, 72, 0), 6'd0, 6'd0, 4'b0001, 3, 0);
		add_row(adr(1, 11, 0), adr(1, 12, 0), adr(1, 13, 0), adr(1, 10, 0), 6'd1, 6'd1, 4'b0000, 0, 0);
		add_row(adr(3, 40, 0), adr(3, 40, 4), adr(3, 40, 8), adr(3, 40, 12), 6'd2, 6'd2, 4'b1000, 0, 0);
		add_row(adr(3, 40, 0), adr(3, 41, 0), adr(3, 40, 4), adr(3, 41, 4), 6'd2, 6'd2, 4'b1000, 1, 0);
		// Back to back on one line, the second read sees the first write.
		add_row(adr(4, 50, 0), adr(7, 70, 0), adr(7, 71, 0), adr(7, 72, 0), 6'd0, 6'd0, 4'b0001, 0, 0);
		add_row(adr(4, 50, 0), adr(7, 70, 0), adr(7, 71, 0), adr(7, 72, 0), 6'd0, 6'd0, 4'b0000, 0, 0);
		// A flush in the middle makes cached lines miss once more.
		add_row(adr(1, 11, 0), adr(1, 12, 0), adr(1, 13, 0), adr(1, 10, 0), 6'd1, 6'd1, 4'b1111, 2, 1);
		add_row(adr(1, 11, 0), adr(1, 12, 0), adr(1, 13, 0), adr(1, 10, 0), 6'd1, 6'd1, 4'b0000, 0, 0);
		add_row(adr(5, 60, 0), adr(5, 61, 0), adr(5, 62, 0), adr(5, 63, 0), 6'd1, 6'd0, 4'b0011, 0, 0);
		add_row(adr(5, 61, 0), adr(5, 60, 0), adr(5, 62, 0), adr(5, 63, 0), 6'd7, 6'd2, 4'b1100, 4, 0);
	endtask

	// Software tag model, applied to the requests in table order.
	task automatic predict(input int i);
		texel_adr_t ad [4];
		line_idx_t  idx [4];
		tag_t       tg [4];
		chan_vec_t  valid;
		chan_vec_t  lead;
		chan_vec_t  miss;
		ad[0] = tab[i].a;
		ad[1] = tab[i].b;
		ad[2] = tab[i].c;
		ad[3] = tab[i].d;
		valid[0] = 1'b1;
		valid[1] = tab[i].xf != '0;
		valid[2] = tab[i].yf != '0;
		valid[3] = valid[1] & valid[2];
		for (int c = 0; c < 4; c++) begin
			idx[c] = ad[c][CACHE_DEPTH-1:LINE_DEPTH];
			tg[c] = ad[c][FML_DEPTH-1:CACHE_DEPTH];
		end
		for (int c = 0; c < 4; c++) begin
			lead[c] = valid[c];
			for (int l = c + 1; l < 4; l++)
				if (valid[l] && (idx[l] == idx[c]))
					lead[c] = 1'b0;
			miss[c] = lead[c] & (~model_valid[idx[c]] | (model_tag[idx[c]] != tg[c]));
		end
		for (int c = 0; c < 4; c++) begin
			if (miss[c]) begin
				model_valid[idx[c]] = 1'b1;
				model_tag[idx[c]] = tg[c];
			end
		end
		assert (miss == tab[i].exp_miss) else begin
			err_other++;
			$display("Table row %0d lists misses %b, but the tag model predicts %b",
				i, tab[i].exp_miss, miss);
		end
		exp_req_q.push_back(reqs[i]);
		exp_miss_q.push_back(miss);
	endtask

	task automatic flush_tags(input int i);
		int busy_cnt;
		busy_cnt = 0;
		while ((out_cnt != i) || busy_o)
			@(negedge sys_clk);
		@(posedge sys_clk);
		#1;
		flush_i = 1'b1;
		@(posedge sys_clk);
		#1;
		flush_i = 1'b0;
		do begin
			@(negedge sys_clk);
			if (busy_o)
				busy_cnt++;
		end while (busy_o);
		assert (busy_cnt == N_LINES) else begin
			err_value++;
			$display("FAILED at %0t: flush held busy_o for %0d cycles, expected %0d",
				$time, busy_cnt, N_LINES);
		end
		for (int l = 0; l < N_LINES; l++)
			model_valid[l] = 1'b0;
		@(posedge sys_clk);
		#1;
	endtask

	task automatic send_requests();
		for (int i = 0; i < N_REQ; i++) begin
			if (tab[i].flush)
				flush_tags(i);
			predict(i);
			pipe_stb_i = 1'b1;
			req_i = reqs[i];
			@(negedge sys_clk);
			while (!pipe_ack_o)
				@(negedge sys_clk);
			@(posedge sys_clk);
			#1;
			pipe_stb_i = 1'b0;
		end
	endtask

	task automatic collect_results();
		tex_req_t  snap_req;
		tex_req_t  want_req;
		chan_vec_t snap_miss;
		chan_vec_t want_miss;
		logic      seen;
		int        held;
		seen = 1'b0;
		held = tab[0].stall;
		while (out_cnt < N_REQ) begin
			@(posedge sys_clk);
			#1;
			pipe_ack_i = held == 0;
			@(negedge sys_clk);
			if (seen) begin
				assert (pipe_stb_o && (req_o == snap_req) && (miss_o == snap_miss)) else begin
					err_value++;
					$display("FAILED at %0t: output of item %0d changed while stalled",
						$time, out_cnt);
				end
			end else if (pipe_stb_o) begin
				if (exp_req_q.size() == 0) begin
					err_other++;
					$display("An output was strobed with no request outstanding");
				end else begin
					want_req = exp_req_q.pop_front();
					want_miss = exp_miss_q.pop_front();
					assert (req_o == want_req) else begin
						err_value++;
						$display("FAILED at %0t: item %0d req_o %h, expected %h",
							$time, out_cnt, req_o, want_req);
					end
					assert (miss_o == want_miss) else begin
						err_value++;
						$display("FAILED at %0t: item %0d miss_o %b, expected %b",
							$time, out_cnt, miss_o, want_miss);
					end
				end
				snap_req = req_o;
				snap_miss = miss_o;
				seen = 1'b1;
			end
			if (seen) begin
				if (pipe_ack_i) begin
					out_cnt++;
					seen = 1'b0;
					if (out_cnt < N_REQ)
						held = tab[out_cnt].stall;
				end else begin
					held--;
				end
			end
		end
		@(posedge sys_clk);
		#1;
		pipe_ack_i = 1'b1;
	endtask

	initial begin
		sys_rst = 1'b1;
		flush_i = 1'b0;
		pipe_stb_i = 1'b0;
		pipe_ack_i = 1'b0;
		req_i = '0;
		out_cnt = 0;
		err_value = 0;
		err_other = 0;
		void'($urandom(SEED));
		fill_table();
		repeat (3) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		@(negedge sys_clk);
		assert (pipe_ack_o && !pipe_stb_o && !busy_o) else begin
			err_other++;
			$display("After reset the stage is not idle and ready for a request");
		end
		@(posedge sys_clk);
		#1;
		fork
			send_requests();
			collect_results();
		join
		repeat (4) begin
			@(negedge sys_clk);
			assert (!pipe_stb_o) else begin
				err_other++;
				$display("An extra output appeared after all requests were delivered");
			end
		end
		$display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
		if ((err_value + err_other) == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== src.f ====
verilog/tmu_tag_pkg.sv
verilog/tmu_tag_ram.sv
verilog/tmu_tag_leader.sv
verilog/tmu_tag_lookup.sv
verilog/tmu_tag_write.sv
verilog/tmu_tag_ctrl.sv
verilog/tmu_tag_top.sv
bench/tb_tmu_tag.sv

// ==== Makefile ====
# Verilator build for the texel cache tag stage.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_tmu_tag
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
